/* verilog.f */
src/microcodePkg.sv
src/ebusPkg.sv
src/condDecode.sv
src/cycleControl.sv
src/runDispatch.sv
src/conRegs.sv
src/conBoard.sv
verif/conBoardTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= conBoardTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/conBoardTb.sv */
module conBoardTb;
  timeunit 1ns;
  timeprecision 1ps;
  import microcodePkg::*;
  import ebusPkg::*;

  localparam int RunSyncStages = 3;
  localparam int RandomCycles  = 4000;
  localparam int WaitLimit     = 20;

  logic conCLK = 1'b0;
  logic CLK;
  condCode_t cond;
  magic_t magic;
  logic vmaFetch, userMode, publicMode, acRef, piReady;
  logic mboxCycReq, xfer, pageError, memBit, skipSatisfied;
  logic diagCtl, diagRead;
  diagCtl_t diagFunc;
  ebusIn_t ebusIn;
  diagRow_t diagRow;
  logic strobeLoadIr, strobeSpecInstr, strobeDiagFunc;
  logic intDisable, pxct, eboxHalted, adr10;
  logic memCycle, piCycle, mboxWait, fmXfer, loadIr, run, start, irStrobe;
  logic [2:0] nicond;
  logic cacheLookEn, cacheLoadEn, ki10Paging, trapEn, ebusDrive;
  diagData_t ebusOut;

  // Reference model state
  logic mRunReq, mStartReq, mMemCycle, mPiCycle, mIntDisable, mPxct, mEboxHalted;
  logic [RunSyncStages-1:0] mRunPipe, mStartPipe;
  logic mParAdr, mParData, mParDir, mLookEn, mLoadEn, mPagingEn, mTrapEn;
  logic [2:0] mNicond;

  integer seed = 46;
  int checks = 0;
  int checkErrors = 0;
  int latencyErrors = 0;

  conBoard #(
    .RunSyncStages(RunSyncStages)
  ) i_conBoard (
    .condLoadIr(strobeLoadIr),
    .condSpecInstr(strobeSpecInstr),
    .condDiagFunc(strobeDiagFunc),
    .*
  );

  always #4 conCLK = ~conCLK;

  task automatic checkBit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      checkErrors++;
      $display("ERROR at time %0t: %s is %b, expected %b", $time, name, got, want);
    end
  endtask

  task automatic compareField(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    if (got !== want) begin
      checkErrors++;
      $display("ERROR at time %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // Skip table, index is the low octal digit of COND
  function automatic logic skipExpected(input logic [5:0] code, input logic expRun,
                                        input logic expStart, input logic expIntReq);
    logic [0:7] group6;
    logic [0:7] group7;
    group6 = {vmaFetch, ~userMode & ~publicMode, userMode, publicMode, 1'b0, mPiCycle, 2'b00};
    group7 = {expIntReq, ~expStart, expRun, 1'b0, mPxct, 1'b0, acRef, 1'b0};
    if (code[5:3] == 3'o6)
      return group6[code[2:0]];
    if (code[5:3] == 3'o7)
      return group7[code[2:0]];
    return 1'b0;
  endfunction

  function automatic logic [0:5] rowExpected(input logic [2:0] row, input logic expRun,
                                             input logic expStart);
    case (row)
      3'd0: return {mParAdr, mParData, mParDir, 3'b000};
      3'd1: return {mLookEn, mLoadEn, ~mPagingEn, mTrapEn, 2'b00};
      3'd2: return {expRun, expStart, mPiCycle, mMemCycle, memBit & mMemCycle, mEboxHalted};
      3'd3: return {mNicond, 3'b000};
      default: return 6'b000000;
    endcase
  endfunction

  always @(negedge conCLK) begin
    logic expRun, expStart, expIntReq, expMboxWait, expIrStrobe;
    if (CLK) begin
      {mRunReq, mStartReq, mMemCycle, mPiCycle} = '0;
      {mIntDisable, mPxct, mEboxHalted} = '0;
      {mParAdr, mParData, mParDir, mLookEn, mLoadEn, mPagingEn, mTrapEn} = '0;
      mRunPipe = '0;
      mStartPipe = '0;
      mNicond = '0;
    end
    expRun = mRunPipe[RunSyncStages-1];
    expStart = mStartPipe[RunSyncStages-1];
    expIntReq = piReady & ~mIntDisable;
    expMboxWait = memBit & mMemCycle;
    expIrStrobe = diagCtl && (diagFunc == diagIrStrobe);
    checkBit("adr10", adr10, skipExpected(cond, expRun, expStart, expIntReq));
    checkBit("condLoadIr", strobeLoadIr, cond == condLoadIr);
    checkBit("condSpecInstr", strobeSpecInstr, cond == condSpecInstr);
    checkBit("condDiagFunc", strobeDiagFunc, cond == condDiagFunc);
    checkBit("intDisable", intDisable, mIntDisable);
    checkBit("pxct", pxct, mPxct);
    checkBit("eboxHalted", eboxHalted, mEboxHalted);
    checkBit("memCycle", memCycle, mMemCycle);
    checkBit("piCycle", piCycle, mPiCycle);
    checkBit("mboxWait", mboxWait, expMboxWait);
    checkBit("fmXfer", fmXfer, expMboxWait & acRef);
    checkBit("loadIr", loadIr, (vmaFetch & mMemCycle) | (cond == condLoadIr) | expIrStrobe);
    checkBit("run", run, expRun);
    checkBit("start", start, expStart);
    checkBit("irStrobe", irStrobe, expIrStrobe);
    compareField("nicond", {5'b0, nicond}, {5'b0, mNicond});
    checkBit("cacheLookEn", cacheLookEn, mLookEn);
    checkBit("cacheLoadEn", cacheLoadEn, mLoadEn);
    checkBit("ki10Paging", ki10Paging, ~mPagingEn);
    checkBit("trapEn", trapEn, mTrapEn);
    checkBit("ebusDrive", ebusDrive, diagRead);
    compareField("ebusOut", {2'b0, ebusOut},
                 diagRead ? {2'b0, rowExpected(diagRow, expRun, expStart)} : 8'h00);
    if (!CLK) begin
      // Next state, using values seen before the coming edge
      mNicond = mPiCycle ? 3'd7 : expIntReq ? 3'd6 : !expRun ? 3'd5 : acRef ? 3'd4 : 3'd0;
      mRunPipe = {mRunPipe[RunSyncStages-2:0], mRunReq};
      mStartPipe = {mStartPipe[RunSyncStages-2:0], mStartReq};
      if (diagCtl && diagFunc == diagSetRun)
        mRunReq = 1'b1;
      else if (diagCtl && diagFunc == diagClrRun)
        mRunReq = 1'b0;
      if (diagCtl && diagFunc == diagContinue)
        mStartReq = 1'b1;
      else if (diagCtl && diagFunc == diagClrRun)
        mStartReq = 1'b0;
      mMemCycle = mboxCycReq | (mMemCycle & ~xfer & ~pageError);
      mPiCycle = ((cond == condSpecInstr) & magic[0]) | (mPiCycle & ~skipSatisfied);
      if (cond == condSpecInstr)
        {mIntDisable, mPxct, mEboxHalted} = {magic[5], magic[4], magic[7]};
      if (cond == condDiagFunc && magic == funcConoPi)
        {mParAdr, mParData, mParDir} = ebusIn[0:2];
      if (cond == condDiagFunc && magic == funcConoPag)
        {mLookEn, mLoadEn, mPagingEn, mTrapEn} = {ebusIn[0:1], ebusIn[3:4]};
    end
  end

  // Called right after a rising edge
  task automatic driveRandom();
    logic [31:0] rnd;
    logic [31:0] bits;
    rnd = $random(seed);
    bits = $random(seed);
    case (rnd[2:0])
      3'd0: cond <= condLoadIr;
      3'd1: cond <= condSpecInstr;
      3'd2, 3'd3: cond <= condDiagFunc;
      3'd4, 3'd5: cond <= condCode_t'({3'o6, rnd[5:3]});
      default: cond <= condCode_t'({3'o7, rnd[5:3]});
    endcase
    // CONO codes mostly under DIAG FUNC
    if (rnd[2:1] == 2'b01 && rnd[7:6] != 2'b00)
      magic <= rnd[8] ? funcConoPi : funcConoPag;
    else
      magic <= rnd[17:9];
    {vmaFetch, userMode, publicMode, acRef, piReady} <= bits[4:0];
    {mboxCycReq, xfer, pageError, memBit, skipSatisfied} <= bits[9:5];
    diagCtl <= (bits[11:10] == 2'b00);
    diagFunc <= diagCtl_t'(bits[14:12]);
    ebusIn <= bits[20:15];
    diagRead <= bits[21];
    diagRow <= diagRow_t'(bits[24:22]);
  endtask

  // Pulse one diagnostic function and count edges until the output moves
  task automatic measureLatency(input diagCtl_t func, input logic watchStart, input logic want);
    int edges;
    string label;
    if (watchStart)
      label = "start";
    else
      label = "run";
    @(posedge conCLK);
    diagCtl <= 1'b1;
    diagFunc <= func;
    @(posedge conCLK);
    diagCtl <= 1'b0;
    edges = 1;
    @(negedge conCLK);
    while ((watchStart ? start : run) !== want && edges < WaitLimit) begin
      @(posedge conCLK);
      edges++;
      @(negedge conCLK);
    end
    if ((watchStart ? start : run) !== want) begin
      latencyErrors++;
      $display("Timeout: %s never became %b after %s", label, want, func.name());
    end else if (edges != RunSyncStages + 1) begin
      latencyErrors++;
      $display("ERROR at time %0t: %s changed %0d edges after %s, expected %0d",
               $time, label, edges, func.name(), RunSyncStages + 1);
    end
  endtask

  initial begin
    CLK <= 1'b1;
    cond <= condSkip6x;
    magic <= '0;
    {vmaFetch, userMode, publicMode, acRef, piReady} <= '0;
    {mboxCycReq, xfer, pageError, memBit, skipSatisfied} <= '0;
    diagCtl <= 1'b0;
    diagFunc <= diagClrRun;
    ebusIn <= '0;
    diagRead <= 1'b0;
    diagRow <= rowParity;
    repeat (2) @(posedge conCLK);
    CLK <= 1'b0;
    for (int n = 0; n < RandomCycles; n++) begin
      driveRandom();
      @(posedge conCLK);
    end
    diagCtl <= 1'b0;
    repeat (RunSyncStages + 2) @(posedge conCLK);
    diagCtl <= 1'b1;
    diagFunc <= diagClrRun;
    @(posedge conCLK);
    diagCtl <= 1'b0;
    repeat (RunSyncStages + 2) @(posedge conCLK);
    measureLatency(diagSetRun, 1'b0, 1'b1);
    measureLatency(diagContinue, 1'b1, 1'b1);
    measureLatency(diagClrRun, 1'b0, 1'b0);
    @(negedge conCLK);
    $display("Checks: %0d, check errors: %0d, latency errors: %0d",
             checks, checkErrors, latencyErrors);
    if (checkErrors == 0 && latencyErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src/conBoard.sv */
module conBoard #(
  parameter int RunSyncStages = 3
) (
  input  logic                    conCLK,
  input  logic                    CLK,
  input  microcodePkg::condCode_t cond,
  input  microcodePkg::magic_t    magic,
  input  logic                    vmaFetch, userMode, publicMode, acRef,
  input  logic                    piReady,
  input  logic                    mboxCycReq, xfer, pageError, memBit,
  input  logic                    skipSatisfied,
  input  logic                    diagCtl,
  input  ebusPkg::diagCtl_t       diagFunc,
  input  ebusPkg::ebusIn_t        ebusIn,
  input  logic                    diagRead,
  input  ebusPkg::diagRow_t       diagRow,
  output logic                    condLoadIr, condSpecInstr, condDiagFunc,
  output logic                    intDisable, pxct, eboxHalted, adr10,
  output logic                    memCycle, piCycle, mboxWait, fmXfer, loadIr,
  output logic                    run, start, irStrobe,
  output logic [2:0]              nicond,
  output logic                    cacheLookEn, cacheLoadEn, ki10Paging, trapEn,
  output logic                    ebusDrive,
  output ebusPkg::diagData_t      ebusOut
);

  logic intReq;

  // PI request masked by the special-instruction flag
  assign intReq = piReady & ~intDisable;

  condDecode i_condDecode (.*);

  cycleControl i_cycleControl (.*);

  runDispatch #(
    .RunSyncStages(RunSyncStages)
  ) i_runDispatch (.*);

  conRegs i_conRegs (.*);

endmodule

/* src/conRegs.sv */
module conRegs (
  input  logic                    conCLK,
  input  logic                    CLK,
  input  microcodePkg::condCode_t cond,
  input  microcodePkg::magic_t    magic,
  input  ebusPkg::ebusIn_t        ebusIn,
  input  logic                    diagRead,
  input  ebusPkg::diagRow_t       diagRow,
  input  logic                    run, start, piCycle, memCycle,
  input  logic                    mboxWait, eboxHalted,
  input  logic [2:0]              nicond,
  output logic                    cacheLookEn, cacheLoadEn, ki10Paging, trapEn,
  output logic                    ebusDrive,
  output ebusPkg::diagData_t      ebusOut
);
  import microcodePkg::*;
  import ebusPkg::*;

  logic conoPi, conoPag;
  logic parAdr, parData, parDir;
  logic pagingEn;
  diagData_t rowData;

  assign conoPi  = (cond == condDiagFunc) && (magic == funcConoPi);
  assign conoPag = (cond == condDiagFunc) && (magic == funcConoPag);

  // CONO PI, write-even parity controls
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      parAdr  <= 1'b0;
      parData <= 1'b0;
      parDir  <= 1'b0;
    end else if (conoPi) begin
      parAdr  <= ebusIn[0];
      parData <= ebusIn[1];
      parDir  <= ebusIn[2];
    end
  end

  // CONO PAG
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      cacheLookEn <= 1'b0;
      cacheLoadEn <= 1'b0;
      pagingEn    <= 1'b0;
      trapEn      <= 1'b0;
    end else if (conoPag) begin
      cacheLookEn <= ebusIn[0];
      cacheLoadEn <= ebusIn[1];
      pagingEn    <= ebusIn[3];
      trapEn      <= ebusIn[4];
    end
  end

  assign ki10Paging = ~pagingEn;

  always_comb begin
    case (diagRow)
      rowParity: rowData = {parAdr, parData, parDir, 3'b000};
      rowPaging: rowData = {cacheLookEn, cacheLoadEn, ki10Paging, trapEn, 2'b00};
      rowState:  rowData = {run, start, piCycle, memCycle, mboxWait, eboxHalted};
      rowNicond: rowData = {nicond, 3'b000};
      default:   rowData = '0;
    endcase
  end

  // Bus released unless a diagnostic read is on
  assign ebusDrive = diagRead;
  assign ebusOut   = diagRead ? rowData : '0;

endmodule

/* src/runDispatch.sv */
module runDispatch #(
  parameter int RunSyncStages = 3
) (
  input  logic              conCLK,
  input  logic              CLK,
  input  logic              diagCtl,
  input  ebusPkg::diagCtl_t diagFunc,
  input  logic              piCycle, intReq, acRef,
  output logic              run, start, irStrobe,
  output logic [2:0]        nicond
);
  import ebusPkg::*;

  logic clrRun, setRun, doContinue;
  logic runReq, startReq;
  logic [RunSyncStages-1:0] runPipe, startPipe;
  logic [2:0] nicondNext;

  assign clrRun     = diagCtl && (diagFunc == diagClrRun);
  assign setRun     = diagCtl && (diagFunc == diagSetRun);
  assign doContinue = diagCtl && (diagFunc == diagContinue);
  assign irStrobe   = diagCtl && (diagFunc == diagIrStrobe);

  // Request flip-flops
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runReq   <= 1'b0;
      startReq <= 1'b0;
    end else begin
      if (setRun)
        runReq <= 1'b1;
      else if (clrRun)
        runReq <= 1'b0;
      if (doContinue)
        startReq <= 1'b1;
      else if (clrRun)
        startReq <= 1'b0;
    end
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runPipe   <= '0;
      startPipe <= '0;
    end else begin
      runPipe[0]   <= runReq;
      startPipe[0] <= startReq;
      for (int i = 1; i < RunSyncStages; i++) begin
        runPipe[i]   <= runPipe[i-1];
        startPipe[i] <= startPipe[i-1];
      end
    end
  end

  assign run   = runPipe[RunSyncStages-1];
  assign start = startPipe[RunSyncStages-1];

  // NICOND priority, PI cycle first
  always_comb begin
    if (piCycle)
      nicondNext = 3'd7;
    else if (intReq)
      nicondNext = 3'd6;
    else if (~run)
      nicondNext = 3'd5;
    else if (acRef)
      nicondNext = 3'd4;
    else
      nicondNext = 3'd0;
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK)
      nicond <= 3'd0;
    else
      nicond <= nicondNext;
  end

  // CLEAR RUN drops run and start on the same edge
  runStartFallTogether: assert property (
    @(posedge conCLK) disable iff (CLK)
    $fell(run) |-> !start
  );

endmodule

/* src/cycleControl.sv */
module cycleControl (
  input  logic                 conCLK,
  input  logic                 CLK,
  input  logic                 mboxCycReq, xfer, pageError, memBit,
  input  logic                 acRef, vmaFetch, skipSatisfied,
  input  logic                 condSpecInstr, condLoadIr, irStrobe,
  input  microcodePkg::magic_t magic,
  output logic                 memCycle, piCycle,
  output logic                 mboxWait, fmXfer, loadIr
);

  logic setPiCycle;

  assign setPiCycle = condSpecInstr & magic[0];

  // Set wins over clear on both
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      memCycle <= 1'b0;
      piCycle  <= 1'b0;
    end else begin
      memCycle <= mboxCycReq | (memCycle & ~xfer & ~pageError);
      piCycle  <= setPiCycle | (piCycle & ~skipSatisfied);
    end
  end

  assign mboxWait = memBit & memCycle;
  // AC references are served from fast memory
  assign fmXfer = mboxWait & acRef;

  // Fetch completes, microcode load or diagnostic strobe
  assign loadIr = (vmaFetch & memCycle) | condLoadIr | irStrobe;

  // A new request wins over a same-cycle transfer or page error
  memRequestWins: assert property (
    @(posedge conCLK) disable iff (CLK)
    mboxCycReq && (xfer || pageError) |=> memCycle
  );

endmodule

/* src/condDecode.sv */
module condDecode (
  input  logic                    conCLK,
  input  logic                    CLK,
  input  microcodePkg::condCode_t cond,
  input  microcodePkg::magic_t    magic,
  input  logic                    vmaFetch, userMode, publicMode, piCycle,
  input  logic                    intReq, start, run, acRef,
  output logic                    condLoadIr, condSpecInstr, condDiagFunc,
  output logic                    intDisable, pxct, eboxHalted,
  output logic                    adr10
);
  import microcodePkg::*;

  logic kernelMode;
  logic skip6x, skip7x;
  logic sel6x, sel7x;

  // Decode strobes
  assign condLoadIr    = (cond == microcodePkg::condLoadIr);
  assign condSpecInstr = (cond == microcodePkg::condSpecInstr);
  assign condDiagFunc  = (cond == microcodePkg::condDiagFunc);

  assign kernelMode = ~userMode & ~publicMode;

  // Group match on the upper octal digit
  assign skip6x = ((cond & 6'o70) == condSkip6x);
  assign skip7x = ((cond & 6'o70) == condSkip7x);

  always_comb begin
    case (cond[2:0])
      3'd0:    sel6x = vmaFetch;
      3'd1:    sel6x = kernelMode;
      3'd2:    sel6x = userMode;
      3'd3:    sel6x = publicMode;
      3'd5:    sel6x = piCycle;
      default: sel6x = 1'b0;
    endcase
  end

  always_comb begin
    case (cond[2:0])
      3'd0:    sel7x = intReq;
      3'd1:    sel7x = ~start;
      3'd2:    sel7x = run;
      3'd4:    sel7x = pxct;
      3'd6:    sel7x = acRef;
      default: sel7x = 1'b0;
    endcase
  end

  assign adr10 = (skip6x & sel6x) | (skip7x & sel7x);

  // Special-instruction flags
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      intDisable <= 1'b0;
      pxct       <= 1'b0;
      eboxHalted <= 1'b0;
    end else if (condSpecInstr) begin
      intDisable <= magic[5];
      pxct       <= magic[4];
      eboxHalted <= magic[7];
    end
  end

  // A PXCT skip right after SPEC INSTR sees the new flag
  pxctSkipAfterLoad: assert property (
    @(posedge conCLK) disable iff (CLK)
    condSpecInstr |=> (cond != 6'o74) || (adr10 == $past(magic[4]))
  );

endmodule

/* src/ebusPkg.sv */
package ebusPkg;

  localparam int EbusInWidth   = 6;
  localparam int DiagDataWidth = 6;
  localparam int DiagCtlWidth  = 3;
  localparam int DiagRowWidth  = 3;

  // Diagnostic control functions
  typedef enum logic [DiagCtlWidth-1:0] {
    diagClrRun   = 3'd0,
    diagSetRun   = 3'd1,
    diagContinue = 3'd2,
    diagIrStrobe = 3'd4
  } diagCtl_t;

  // EBUS data bits 18 to 23
  typedef logic [0:EbusInWidth-1] ebusIn_t;

  // Diagnostic read rows
  typedef enum logic [DiagRowWidth-1:0] {
    rowParity = 3'd0,
    rowPaging = 3'd1,
    rowState  = 3'd2,
    rowNicond = 3'd3
  } diagRow_t;

  typedef logic [0:DiagDataWidth-1] diagData_t;

endpackage

/* src/microcodePkg.sv */
package microcodePkg;

  localparam int CondWidth  = 6;
  localparam int MagicWidth = 9;

  // COND field of the microword
  typedef enum logic [CondWidth-1:0] {
    condLoadIr    = 6'o14,
    condSpecInstr = 6'o15,
    condDiagFunc  = 6'o20,
    // Skip groups, only the upper octal digit is matched
    condSkip6x    = 6'o60,
    condSkip7x    = 6'o70
  } condCode_t;

  // MAGIC field, bit 0 is the MSB
  typedef logic [0:MagicWidth-1] magic_t;

  // MAGIC codes used under DIAG FUNC
  typedef enum logic [0:MagicWidth-1] {
    funcConoPi  = 9'o015,
    funcConoPag = 9'o016
  } magicFunc_t;

endpackage
